// ==== source/clk_gen_pkg.sv ====
// clk_gen_pkg: divider width and type, reset divide value, bypass rule, slow ratio, sync depth
package clk_gen_pkg;

    // width of one programmable divide value
    localparam int unsigned DIV_W = 8;

    // divide value as carried on the config handshake and readback
    typedef logic [DIV_W-1:0] div_val_t;

    // dividers come out of reset in bypass
    localparam div_val_t DIV_RESET_VAL = '0;

    // divide values up to this one select bypass, clk_o follows sys_clk_i
    localparam div_val_t BYPASS_MAX = div_val_t'(1);

    // slow timer clock period in sys_clk_i cycles, kept small for simulation
    // must stay even so both half periods are equal
    localparam int unsigned SLOW_CLK_RATIO = 32;
    localparam int unsigned SLOW_HALF      = SLOW_CLK_RATIO / 2;
    localparam int unsigned SLOW_CNT_W     = $clog2(SLOW_HALF);

    // flops in each reset synchronizer chain
    localparam int unsigned RST_SYNC_STAGES = 2;

    // 0 and 1 both mean no division
    function automatic logic div_is_bypass(div_val_t val);
        logic byp;
        byp = (val <= BYPASS_MAX);
        return byp;
    endfunction

endpackage

// ==== source/clk_regmap_pkg.sv ====
// clk_regmap_pkg: APB address and data widths, divider register offsets, register slave states
package clk_regmap_pkg;

    // apb bus widths seen by the clock register block
    localparam int unsigned APB_ADDR_W = 12;
    localparam int unsigned APB_DATA_W = 32;

    // register offsets inside the 4 KiB clock control window
    // soc clock divide value
    localparam logic [APB_ADDR_W-1:0] SOC_DIV_OFFS     = 12'hF00;
    // cluster clock divide value
    localparam logic [APB_ADDR_W-1:0] CLUSTER_DIV_OFFS = 12'hF08;
    // peripheral clock divide value
    localparam logic [APB_ADDR_W-1:0] PER_DIV_OFFS     = 12'hF10;

    // register slave access states
    // IDLE waits for psel and penable together, captures the request
    // ACCESS decodes and either reads or waits on a divider handshake
    // DONE drives the single pready pulse
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ACCESS = 2'd1,
        DONE   = 2'd2
    } regs_state_e;

endpackage

// ==== source/div_cfg_if.sv ====
// div_cfg_if: one divider's config valid/ready handshake and active value readback
`timescale 1ns/1ns

interface div_cfg_if
    import clk_gen_pkg::*;
();

    // new divide value offered by the register slave
    logic     cfg_valid;
    div_val_t cfg_data;
    // single cycle pulse when the divider takes cfg_data
    logic     cfg_ready;
    // divide value the divider is running with right now
    div_val_t cur_div;

    // register slave side
    modport ctrl (
        output cfg_valid,
        output cfg_data,
        input  cfg_ready,
        input  cur_div
    );

    // divider side
    modport div (
        input  cfg_valid,
        input  cfg_data,
        output cfg_ready,
        output cur_div
    );

endinterface

// ==== source/apb_clk_regs.sv ====
// apb_clk_regs: APB slave for the three divider registers, decode, access FSM and read mux
`timescale 1ns/1ns

module apb_clk_regs
    import clk_gen_pkg::*;
    import clk_regmap_pkg::*;
(
    input  logic                  sys_clk_i,
    input  logic                  rstn_glob_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic                  pready_o,
    div_cfg_if.ctrl               soc_cfg,
    div_cfg_if.ctrl               cluster_cfg,
    div_cfg_if.ctrl               per_cfg
);

    regs_state_e state_q, state_d;

    // captured request
    logic [APB_ADDR_W-1:0] addr_q;
    logic                  wr_q;
    div_val_t              wdata_q;
    logic [APB_DATA_W-1:0] rdata_q;

    // decode of the captured offset
    logic     sel_soc;
    logic     sel_cluster;
    logic     sel_per;
    logic     sel_hit;
    logic     sel_ready;
    div_val_t sel_cur;

    // the master raises psel and penable in the same cycle
    logic req_start;

    assign req_start = psel_i && penable_i;

    assign sel_soc     = (addr_q == SOC_DIV_OFFS);
    assign sel_cluster = (addr_q == CLUSTER_DIV_OFFS);
    assign sel_per     = (addr_q == PER_DIV_OFFS);
    assign sel_hit     = sel_soc || sel_cluster || sel_per;

    // handshake and readback of the addressed divider
    always_comb begin
        sel_ready = 1'b0;
        sel_cur   = '0;
        if (sel_soc) begin
            sel_ready = soc_cfg.cfg_ready;
            sel_cur   = soc_cfg.cur_div;
        end else if (sel_cluster) begin
            sel_ready = cluster_cfg.cfg_ready;
            sel_cur   = cluster_cfg.cur_div;
        end else if (sel_per) begin
            sel_ready = per_cfg.cfg_ready;
            sel_cur   = per_cfg.cur_div;
        end
    end

    // valid stays high for the whole write access while wdata_q holds the data
    assign soc_cfg.cfg_valid     = (state_q == ACCESS) && wr_q && sel_soc;
    assign cluster_cfg.cfg_valid = (state_q == ACCESS) && wr_q && sel_cluster;
    assign per_cfg.cfg_valid     = (state_q == ACCESS) && wr_q && sel_per;

    // one shared write data bus since only one valid is ever high
    assign soc_cfg.cfg_data     = wdata_q;
    assign cluster_cfg.cfg_data = wdata_q;
    assign per_cfg.cfg_data     = wdata_q;

    // next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (req_start) begin
                    state_d = ACCESS;
                end
            end
            ACCESS: begin
                // reads and unmapped writes finish here
                // mapped writes stay until the divider takes the value
                if (!wr_q || !sel_hit || sel_ready) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge sys_clk_i, negedge rstn_glob_i) begin
        if (!rstn_glob_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request capture and read data
    always_ff @(posedge sys_clk_i) begin
        if ((state_q == IDLE) && req_start) begin
            addr_q  <= paddr_i;
            wr_q    <= pwrite_i;
            // dividers only take the low byte
            wdata_q <= pwdata_i[DIV_W-1:0];
        end
        if ((state_q == ACCESS) && !wr_q) begin
            // unmapped offsets give sel_cur of 0
            rdata_q <= {{(APB_DATA_W-DIV_W){1'b0}}, sel_cur};
        end
    end

    assign prdata_o = rdata_q;
    assign pready_o = (state_q == DONE);

endmodule

// ==== source/clk_div_prog.sv ====
// clk_div_prog: programmable integer clock divider with bypass and period-boundary reload
`timescale 1ns/1ns

module clk_div_prog
    import clk_gen_pkg::*;
(
    input  logic   sys_clk_i,
    input  logic   rstn_glob_i,
    div_cfg_if.div cfg,
    output logic   clk_o
);

    // active divide value and derived bypass flag
    div_val_t div_q, div_d;
    logic     bypass_q, bypass_d;

    // position inside the current output period, 0 to div_q-1
    div_val_t cnt_q, cnt_d;

    // divided level, high for the first floor(N/2) cycles
    logic lvl_q, lvl_d;

    logic period_end;
    logic accept;

    // last cycle of a period, every cycle counts as one in bypass
    assign period_end = bypass_q || (cnt_q == (div_q - div_val_t'(1)));

    // new value only at a boundary so the output never gets a short pulse
    assign accept = cfg.cfg_valid && period_end;

    assign cfg.cfg_ready = accept;
    assign cfg.cur_div   = div_q;

    always_comb begin
        div_d    = div_q;
        bypass_d = bypass_q;
        cnt_d    = cnt_q + div_val_t'(1);
        if (accept) begin
            // new period starts in the following cycle
            div_d    = cfg.cfg_data;
            bypass_d = div_is_bypass(cfg.cfg_data);
            cnt_d    = '0;
        end else if (period_end) begin
            cnt_d = '0;
        end
        // level for the next cycle
        // count 0 is always high for N of 2 or more
        lvl_d = !bypass_d && (cnt_d < (div_d >> 1));
    end

    always_ff @(posedge sys_clk_i, negedge rstn_glob_i) begin
        if (!rstn_glob_i) begin
            div_q    <= DIV_RESET_VAL;
            bypass_q <= div_is_bypass(DIV_RESET_VAL);
            cnt_q    <= '0;
            lvl_q    <= 1'b0;
        end else begin
            div_q    <= div_d;
            bypass_q <= bypass_d;
            cnt_q    <= cnt_d;
            lvl_q    <= lvl_d;
        end
    end

    // output clock mux
    // bypass_q and lvl_q both change right after a rising sys edge,
    // while sys_clk_i is high, so the switch cannot cut a pulse short
    // entering bypass happens only with lvl_q low at the period end
    // leaving bypass loads lvl_q high, same as sys_clk_i at that moment
    always_comb begin
        if (bypass_q) begin
            clk_o = sys_clk_i;
        end else begin
            clk_o = lvl_q;
        end
    end

endmodule

// ==== source/clk_div_fixed.sv ====
// clk_div_fixed: fixed ratio divider with 50% duty cycle for the slow timer clock
`timescale 1ns/1ns

module clk_div_fixed
    import clk_gen_pkg::*;
(
    input  logic sys_clk_i,
    input  logic rstn_glob_i,
    output logic clk_o
);

    // counts sys cycles within one half period
    logic [SLOW_CNT_W-1:0] half_cnt_q;
    logic                  half_end;
    // toggle flop, low after reset
    logic                  clk_q;

    assign half_end = (half_cnt_q == SLOW_CNT_W'(SLOW_HALF - 1));

    always_ff @(posedge sys_clk_i, negedge rstn_glob_i) begin
        if (!rstn_glob_i) begin
            half_cnt_q <= '0;
            clk_q      <= 1'b0;
        end else if (half_end) begin
            // flip every SLOW_HALF cycles, full period SLOW_CLK_RATIO
            half_cnt_q <= '0;
            clk_q      <= ~clk_q;
        end else begin
            half_cnt_q <= half_cnt_q + SLOW_CNT_W'(1);
        end
    end

    // straight from a flop, no glitch
    assign clk_o = clk_q;

endmodule

// ==== source/rst_sync.sv ====
// rst_sync: reset synchronizer, asynchronous assert and synchronous release
`timescale 1ns/1ns

module rst_sync
    import clk_gen_pkg::*;
(
    input  logic clk_i,
    input  logic rstn_i,
    output logic rstn_o
);

    // shift chain, a 1 enters at the bottom after release
    logic [RST_SYNC_STAGES-1:0] sync_q;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            // whole chain clears at once, output drops without a clock
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    // high on the RST_SYNC_STAGES-th rising clk_i edge after release
    assign rstn_o = sync_q[RST_SYNC_STAGES-1];

endmodule

// ==== source/clk_rst_gen.sv ====
// clk_rst_gen: clock and reset generator top with APB registers, dividers and reset synchronizers
`timescale 1ns/1ns

module clk_rst_gen
    import clk_regmap_pkg::*;
(
    input  logic                  sys_clk_i,
    input  logic                  rstn_glob_i,

    // apb slave, psel and penable rise together
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,

    // generated clocks
    output logic                  clk_soc_o,
    output logic                  clk_cluster_o,
    output logic                  clk_per_o,
    output logic                  clk_slow_o,

    // resets released in step with their own clock
    output logic                  rstn_soc_sync_o,
    output logic                  rstn_cluster_sync_o
);

    // config link per programmable divider
    div_cfg_if soc_cfg ();
    div_cfg_if cluster_cfg ();
    div_cfg_if per_cfg ();

    // error response is not supported, every access completes
    assign pslverr_o = 1'b0;

    // register slave, whole block on sys_clk_i
    apb_clk_regs apb_clk_regs_i (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .soc_cfg     (soc_cfg.ctrl),
        .cluster_cfg (cluster_cfg.ctrl),
        .per_cfg     (per_cfg.ctrl)
    );

    // sys_clk_i to soc clock
    clk_div_prog soc_div_i (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .cfg         (soc_cfg.div),
        .clk_o       (clk_soc_o)
    );

    // sys_clk_i to cluster clock
    clk_div_prog cluster_div_i (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .cfg         (cluster_cfg.div),
        .clk_o       (clk_cluster_o)
    );

    // sys_clk_i to peripheral clock
    clk_div_prog per_div_i (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .cfg         (per_cfg.div),
        .clk_o       (clk_per_o)
    );

    // slow timer reference
    clk_div_fixed slow_div_i (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .clk_o       (clk_slow_o)
    );

    // each reset synchronized to the clock of its own domain
    rst_sync soc_rst_sync_i (
        .clk_i  (clk_soc_o),
        .rstn_i (rstn_glob_i),
        .rstn_o (rstn_soc_sync_o)
    );

    rst_sync cluster_rst_sync_i (
        .clk_i  (clk_cluster_o),
        .rstn_i (rstn_glob_i),
        .rstn_o (rstn_cluster_sync_o)
    );

endmodule

// ==== tb/tb_clk_rst_gen.sv ====
// tb_clk_rst_gen: stimulus table, clock and reset, APB tasks, period measurement, checks, watchdog
`timescale 1ns/1ns

module tb_clk_rst_gen;

    // sys clock period in ns
    localparam int CLK_PERIOD = 100;
    // slow timer clock period in sys cycles
    localparam int SLOW_RATIO = 32;
    // register offsets as seen on the bus
    localparam logic [11:0] SOC_OFFS = 12'hF00;
    localparam logic [11:0] CL_OFFS  = 12'hF08;
    localparam logic [11:0] PER_OFFS = 12'hF10;
    localparam logic [11:0] BAD_OFFS = 12'hF04;
    // table operations
    localparam logic [1:0] OP_WR  = 2'd0;
    localparam logic [1:0] OP_RD  = 2'd1;
    localparam logic [1:0] OP_RST = 2'd2;

    // one row holds operation, offset, data, expected read value and expected periods
    typedef struct packed {
        logic [1:0]  op;
        logic [11:0] offs;
        logic [31:0] data;
        logic [31:0] exp_rd;
        logic [7:0]  p_soc;
        logic [7:0]  p_cl;
        logic [7:0]  p_per;
    } entry_t;

    logic        sys_clk;
    logic        rstn_glob;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        clk_soc;
    logic        clk_cluster;
    logic        clk_per;
    logic        clk_slow;
    logic        rstn_soc_sync;
    logic        rstn_cluster_sync;

    entry_t tbl[$];
    integer seed;
    int     cycle_cnt;
    int     cycle_limit;
    // periods in force before the current row give the write latency bound
    int     prev_soc;
    int     prev_cl;
    int     prev_per;

    clk_rst_gen clk_rst_gen_i (
        .sys_clk_i           (sys_clk),
        .rstn_glob_i         (rstn_glob),
        .psel_i              (psel),
        .penable_i           (penable),
        .pwrite_i            (pwrite),
        .paddr_i             (paddr),
        .pwdata_i            (pwdata),
        .prdata_o            (prdata),
        .pready_o            (pready),
        .pslverr_o           (pslverr),
        .clk_soc_o           (clk_soc),
        .clk_cluster_o       (clk_cluster),
        .clk_per_o           (clk_per),
        .clk_slow_o          (clk_slow),
        .rstn_soc_sync_o     (rstn_soc_sync),
        .rstn_cluster_sync_o (rstn_cluster_sync)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // divide values 0 and 1 mean bypass with one sys cycle per period
    function automatic int exp_period(input logic [7:0] n);
        return (n <= 8'd1) ? 1 : int'(n);
    endfunction

    function automatic bit is_mapped(input logic [11:0] offs);
        return (offs == SOC_OFFS) || (offs == CL_OFFS) || (offs == PER_OFFS);
    endfunction

    function automatic int old_period(input logic [11:0] offs);
        if (offs == SOC_OFFS) begin
            return prev_soc;
        end else if (offs == CL_OFFS) begin
            return prev_cl;
        end
        return prev_per;
    endfunction

    task automatic add_entry(input logic [1:0] op, input logic [11:0] offs,
                             input logic [31:0] data, input logic [31:0] exp_rd,
                             input int p_soc, input int p_cl, input int p_per);
        entry_t e;
        e.op     = op;
        e.offs   = offs;
        e.data   = data;
        e.exp_rd = exp_rd;
        e.p_soc  = 8'(p_soc);
        e.p_cl   = 8'(p_cl);
        e.p_per  = 8'(p_per);
        tbl.push_back(e);
    endtask

    // select 0 is soc, 1 cluster, 2 per and anything else slow
    task automatic wait_rise(input int sel);
        case (sel)
            0: @(posedge clk_soc);
            1: @(posedge clk_cluster);
            2: @(posedge clk_per);
            default: @(posedge clk_slow);
        endcase
    endtask

    // first edge is skipped so a period change in flight is not measured
    task automatic measure_period(input int sel, output int cycles);
        time t_first;
        time t_second;
        wait_rise(sel);
        wait_rise(sel);
        t_first = $time;
        wait_rise(sel);
        t_second = $time;
        cycles = int'((t_second - t_first) / CLK_PERIOD);
    endtask

    // psel and penable rise together and stay up until pready
    // lat counts cycles from the start to pready
    task automatic apb_access(input logic wr, input logic [11:0] offs, input logic [31:0] data,
                              output logic [31:0] rdata, output int lat);
        @(negedge sys_clk);
        psel    = 1'b1;
        penable = 1'b1;
        pwrite  = wr;
        paddr   = offs;
        pwdata  = data;
        @(negedge sys_clk);
        lat = 1;
        while (!pready) begin
            @(negedge sys_clk);
            lat = lat + 1;
        end
        rdata = prdata;
        check_val("pslverr_o", pslverr, 32'd0);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        // pready is a single cycle pulse
        @(negedge sys_clk);
        check_val("pready_o", pready, 32'd0);
    endtask

    task automatic apb_write(input logic [11:0] offs, input logic [31:0] data, output int lat);
        logic [31:0] unused;
        apb_access(1'b1, offs, data, unused, lat);
    endtask

    task automatic apb_read(input logic [11:0] offs, output logic [31:0] rdata, output int lat);
        apb_access(1'b0, offs, 32'h0, rdata, lat);
    endtask

    // synced resets come back within a few cycles
    // then the slow clock period is measured
    task automatic release_checks();
        int per;
        repeat (3) @(negedge sys_clk);
        check_val("rstn_soc_sync_o", rstn_soc_sync, 32'd1);
        check_val("rstn_cluster_sync_o", rstn_cluster_sync, 32'd1);
        measure_period(3, per);
        check_val("clk_slow_o period", per, SLOW_RATIO);
    endtask

    task automatic pulse_reset();
        @(negedge sys_clk);
        rstn_glob = 1'b0;
        // synced resets drop without waiting for a clock
        #1;
        check_val("rstn_soc_sync_o", rstn_soc_sync, 32'd0);
        check_val("rstn_cluster_sync_o", rstn_cluster_sync, 32'd0);
        repeat (16) @(negedge sys_clk);
        rstn_glob = 1'b1;
        release_checks();
    endtask

    // watchdog whose limit is set once the table is built
    initial begin
        cycle_cnt = 0;
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge sys_clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout: the tests did not finish within %0d clock cycles", cycle_limit);
        $display("Regression failed");
        $fatal(1, "stopped by the cycle limit");
    end

    initial begin
        entry_t      e;
        entry_t      last;
        logic [31:0] rnd;
        logic [31:0] rd;
        int          lat;
        int          per;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        rstn_glob   = 1'b0;
        cycle_limit = 0;
        seed        = 32'h73b0;
        prev_soc    = 1;
        prev_cl     = 1;
        prev_per    = 1;

        // reset values, then each divider written and read back
        add_entry(OP_RD, SOC_OFFS, 32'h0, 32'h0, 1, 1, 1);
        add_entry(OP_RD, CL_OFFS, 32'h0, 32'h0, 1, 1, 1);
        add_entry(OP_RD, PER_OFFS, 32'h0, 32'h0, 1, 1, 1);
        add_entry(OP_WR, SOC_OFFS, 32'h4, 32'h0, 4, 1, 1);
        add_entry(OP_RD, SOC_OFFS, 32'h0, 32'h4, 4, 1, 1);
        add_entry(OP_WR, CL_OFFS, 32'h6, 32'h0, 4, 6, 1);
        add_entry(OP_RD, CL_OFFS, 32'h0, 32'h6, 4, 6, 1);
        add_entry(OP_WR, PER_OFFS, 32'h3, 32'h0, 4, 6, 3);
        add_entry(OP_RD, PER_OFFS, 32'h0, 32'h3, 4, 6, 3);
        // unmapped offset changes nothing and reads 0
        add_entry(OP_WR, BAD_OFFS, 32'ha, 32'h0, 4, 6, 3);
        add_entry(OP_RD, BAD_OFFS, 32'h0, 32'h0, 4, 6, 3);
        add_entry(OP_RD, SOC_OFFS, 32'h0, 32'h4, 4, 6, 3);
        add_entry(OP_RD, CL_OFFS, 32'h0, 32'h6, 4, 6, 3);
        add_entry(OP_RD, PER_OFFS, 32'h0, 32'h3, 4, 6, 3);
        // back to bypass with 1 and 0
        add_entry(OP_WR, SOC_OFFS, 32'h1, 32'h0, 1, 6, 3);
        add_entry(OP_RD, SOC_OFFS, 32'h0, 32'h1, 1, 6, 3);
        add_entry(OP_WR, CL_OFFS, 32'h0, 32'h0, 1, 1, 3);
        add_entry(OP_RD, CL_OFFS, 32'h0, 32'h0, 1, 1, 3);
        // only the low byte of pwdata is taken
        add_entry(OP_WR, PER_OFFS, 32'h105, 32'h0, 1, 1, 5);
        add_entry(OP_RD, PER_OFFS, 32'h0, 32'h5, 1, 1, 5);
        add_entry(OP_WR, SOC_OFFS, 32'h9, 32'h0, 9, 1, 5);
        // reset mid-run clears every register
        add_entry(OP_RST, 12'h0, 32'h0, 32'h0, 1, 1, 1);
        add_entry(OP_RD, SOC_OFFS, 32'h0, 32'h0, 1, 1, 1);
        add_entry(OP_RD, CL_OFFS, 32'h0, 32'h0, 1, 1, 1);
        add_entry(OP_RD, PER_OFFS, 32'h0, 32'h0, 1, 1, 1);
        // random back-to-back writes to the soc divider and a readback of the last one
        last = tbl[tbl.size()-1];
        rnd  = '0;
        for (int k = 0; k < 4; k++) begin
            rnd = {$random(seed)} % 16;
            add_entry(OP_WR, SOC_OFFS, rnd, 32'h0, exp_period(rnd[7:0]), last.p_cl, last.p_per);
        end
        add_entry(OP_RD, SOC_OFFS, 32'h0, rnd, exp_period(rnd[7:0]), last.p_cl, last.p_per);
        cycle_limit = 16 + 300 * tbl.size();

        repeat (16) @(negedge sys_clk);
        rstn_glob = 1'b1;
        release_checks();

        foreach (tbl[i]) begin
            e = tbl[i];
            case (e.op)
                OP_WR: begin
                    apb_write(e.offs, e.data, lat);
                    if (is_mapped(e.offs)) begin
                        // wait bounded by the old period plus the access overhead
                        check_val("write latency in bound", 32'(lat <= old_period(e.offs) + 2),
                                  32'd1);
                    end else begin
                        check_val("unmapped write latency", lat, 32'd2);
                    end
                end
                OP_RD: begin
                    apb_read(e.offs, rd, lat);
                    check_val("read latency", lat, 32'd2);
                    check_val("prdata_o", rd, e.exp_rd);
                end
                default: begin
                    pulse_reset();
                end
            endcase
            measure_period(0, per);
            check_val("clk_soc_o period", per, 32'(e.p_soc));
            measure_period(1, per);
            check_val("clk_cluster_o period", per, 32'(e.p_cl));
            measure_period(2, per);
            check_val("clk_per_o period", per, 32'(e.p_per));
            prev_soc = e.p_soc;
            prev_cl  = e.p_cl;
            prev_per = e.p_per;
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== sources.f ====
source/clk_gen_pkg.sv
source/clk_regmap_pkg.sv
source/div_cfg_if.sv
source/apb_clk_regs.sv
source/clk_div_prog.sv
source/clk_div_fixed.sv
source/rst_sync.sv
source/clk_rst_gen.sv
tb/tb_clk_rst_gen.sv
